/* hdl/av_pkg.sv */
package av_pkg;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pixel_t;

  // raw video from the core side
  typedef struct packed {
    pixel_t pixel;
    logic   hs;
    logic   vs;
    logic   hblank;
    logic   vblank;
  } video_in_t;

  // formatted video towards the scaler
  typedef struct packed {
    pixel_t pixel;
    logic   de;
    logic   hs;
    logic   vs;
  } video_out_t;

  typedef struct packed {
    logic signed [15:0] left;
    logic signed [15:0] right;
  } audio_pair_t;

  // bit 13 alone marks a border slot for the scaler
  localparam pixel_t BORDER_SLOT_CODE = '{r: 8'h00, g: 8'h20, b: 8'h00};

endpackage

/* hdl/core_cfg_pkg.sv */
package core_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // bus geometry and register map
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  // byte offsets
  localparam logic [ADDR_W-1:0] OFS_RESET = 8'h00;
  localparam logic [ADDR_W-1:0] OFS_BOOT  = 8'h04;
  localparam logic [ADDR_W-1:0] OFS_RUN   = 8'h08;

  // boot settings fields
  localparam int BOOT_SGB_BIT = 0;

  // run settings fields
  localparam int RUN_FF_SND_BIT = 2;
  localparam int RUN_FF_EN_BIT  = 3;
  localparam int RUN_BORDER_BIT = 4;
  localparam int RUN_BW_BIT     = 7;

  ////////////////////////////////////////////////////////////
  // apb request / response
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // fields pulled out of the two settings words
  typedef struct packed {
    logic sgb_en;
    logic ff_snd_en;
    logic ff_en;
    logic border_en;
    logic bw_en;
  } core_settings_t;

  typedef enum logic [1:0] {
    SEL_RESET,
    SEL_BOOT,
    SEL_RUN,
    SEL_NONE
  } reg_sel_e;

endpackage

/* hdl/core_reset_timer.sv */
`timescale 1ns/1ps

module core_reset_timer #(
  parameter int RESET_HOLD = 8000
) (
  input  logic clk_sys,
  input  logic arst_n,
  input  logic reset_req,
  output logic core_reset
);

  localparam int CNT_W = $clog2(RESET_HOLD + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      count      <= '0;
      core_reset <= 1'b0;
    end else begin
      core_reset <= (count != '0);
      // a new request during the hold starts over
      if (reset_req) begin
        count <= CNT_W'(RESET_HOLD);
      end else if (count != '0) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* hdl/core_shell_top.sv */
`timescale 1ns/1ps

module core_shell_top
  import core_cfg_pkg::*;
  import av_pkg::*;
#(
  parameter int RESET_HOLD = 8000,
  parameter int TAP_CYCLES = 3200000,
  parameter int HS_DELAY   = 7
) (
  input  logic        clk_sys,
  input  logic        arst_n,
  input  apb_req_t    apb_req,
  output apb_rsp_t    apb_rsp,
  input  logic        ff_button,
  input  logic        dl_busy,
  input  audio_pair_t audio_in,
  output audio_pair_t audio_out,
  input  video_in_t   video_in,
  output video_out_t  video_out,
  output logic        fast_forward,
  output logic        core_reset
);

  core_settings_t settings;
  logic           reset_req;

  settings_regs i_settings_regs (
    .clk_sys   (clk_sys),
    .arst_n    (arst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .settings  (settings),
    .reset_req (reset_req)
  );

  core_reset_timer #(
    .RESET_HOLD (RESET_HOLD)
  ) i_core_reset_timer (
    .clk_sys    (clk_sys),
    .arst_n     (arst_n),
    .reset_req  (reset_req),
    .core_reset (core_reset)
  );

  ff_control #(
    .TAP_CYCLES (TAP_CYCLES)
  ) i_ff_control (
    .clk_sys      (clk_sys),
    .arst_n       (arst_n),
    .settings     (settings),
    .ff_button    (ff_button),
    .dl_busy      (dl_busy),
    .audio_in     (audio_in),
    .fast_forward (fast_forward),
    .audio_out    (audio_out)
  );

  video_out_fmt #(
    .HS_DELAY (HS_DELAY)
  ) i_video_out_fmt (
    .clk_sys   (clk_sys),
    .arst_n    (arst_n),
    .settings  (settings),
    .video_in  (video_in),
    .video_out (video_out)
  );

endmodule

/* hdl/ff_control.sv */
`timescale 1ns/1ps

module ff_control
  import core_cfg_pkg::*;
  import av_pkg::*;
#(
  parameter int TAP_CYCLES = 3200000
) (
  input  logic           clk_sys,
  input  logic           arst_n,
  input  core_settings_t settings,
  input  logic           ff_button,
  input  logic           dl_busy,
  input  audio_pair_t    audio_in,
  output logic           fast_forward,
  output audio_pair_t    audio_out
);

  localparam int CNT_W = $clog2(TAP_CYCLES + 1);

  typedef enum logic [1:0] {
    IDLE,
    HOLD_FROM_IDLE,
    LATCHED,
    HOLD_FROM_LATCHED
  } ff_state_e;

  ff_state_e        state;
  ff_state_e        state_nxt;
  logic [CNT_W-1:0] press_cnt;
  logic             press;
  logic             is_tap;

  // no fast-forward while a download is running
  assign press  = ff_button & settings.ff_en & ~dl_busy;
  assign is_tap = press_cnt < CNT_W'(TAP_CYCLES);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (press) begin
          state_nxt = HOLD_FROM_IDLE;
        end
      end
      HOLD_FROM_IDLE: begin
        if (!press) begin
          state_nxt = is_tap ? LATCHED : IDLE;
        end
      end
      LATCHED: begin
        if (press) begin
          state_nxt = HOLD_FROM_LATCHED;
        end
      end
      HOLD_FROM_LATCHED: begin
        if (!press) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      state        <= IDLE;
      press_cnt    <= '0;
      fast_forward <= 1'b0;
    end else begin
      state        <= state_nxt;
      fast_forward <= (state_nxt != IDLE);
      // press length saturates once it can no longer be a tap
      if (state == IDLE && press) begin
        press_cnt <= CNT_W'(1);
      end else if (state == HOLD_FROM_IDLE && press && is_tap) begin
        press_cnt <= press_cnt + 1'b1;
      end
    end
  end

  // mute both channels unless ff sound is allowed
  assign audio_out = (fast_forward && !settings.ff_snd_en) ? '0 : audio_in;

endmodule

/* hdl/settings_regs.sv */
`timescale 1ns/1ps

module settings_regs
  import core_cfg_pkg::*;
(
  input  logic           clk_sys,
  input  logic           arst_n,
  input  apb_req_t       apb_req,
  output apb_rsp_t       apb_rsp,
  output core_settings_t settings,
  output logic           reset_req
);

  logic [DATA_W-1:0] boot_q;
  logic [DATA_W-1:0] run_q;
  reg_sel_e          sel;
  logic              access;
  logic              wr_access;

  // access phase of a transfer
  assign access    = apb_req.psel & apb_req.penable;
  assign wr_access = access & apb_req.pwrite;

  always_comb begin
    case (apb_req.paddr)
      OFS_RESET: sel = SEL_RESET;
      OFS_BOOT:  sel = SEL_BOOT;
      OFS_RUN:   sel = SEL_RUN;
      default:   sel = SEL_NONE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // register writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      boot_q    <= '0;
      run_q     <= '0;
      reset_req <= 1'b0;
    end else begin
      // reset command and boot settings both restart the core
      reset_req <= wr_access && (sel == SEL_RESET || sel == SEL_BOOT);
      if (wr_access && sel == SEL_BOOT) begin
        boot_q <= apb_req.pwdata;
      end
      if (wr_access && sel == SEL_RUN) begin
        run_q <= apb_req.pwdata;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  always_comb begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access && (sel == SEL_NONE);
    case (sel)
      SEL_BOOT: apb_rsp.prdata = boot_q;
      SEL_RUN:  apb_rsp.prdata = run_q;
      // reset command is write-only
      default:  apb_rsp.prdata = '0;
    endcase
  end

  // field decode
  assign settings.sgb_en    = boot_q[BOOT_SGB_BIT];
  assign settings.ff_snd_en = run_q[RUN_FF_SND_BIT];
  assign settings.ff_en     = run_q[RUN_FF_EN_BIT];
  assign settings.border_en = run_q[RUN_BORDER_BIT];
  assign settings.bw_en     = run_q[RUN_BW_BIT];

endmodule

/* hdl/video_out_fmt.sv */
`timescale 1ns/1ps

module video_out_fmt
  import core_cfg_pkg::*;
  import av_pkg::*;
#(
  parameter int HS_DELAY = 7
) (
  input  logic           clk_sys,
  input  logic           arst_n,
  input  core_settings_t settings,
  input  video_in_t      video_in,
  output video_out_t     video_out
);

  localparam int CNT_W = $clog2(HS_DELAY + 1);

  // input stage
  pixel_t           pix_q;
  logic             de_q;
  logic             hs_q;
  logic             vs_q;
  logic             hs_prev;
  logic             vs_prev;
  logic [CNT_W-1:0] hs_cnt;

  // output stage
  pixel_t           out_pix;
  pixel_t           pix_nxt;
  logic             out_de;
  logic             out_hs;
  logic             out_vs;

  function automatic logic [7:0] luma(pixel_t p);
    logic [7:0] sum;
    sum = (p.r >> 2) + (p.r >> 5) + (p.g >> 1) + (p.g >> 4);
    sum = sum + (p.b >> 4) + (p.b >> 5);
    return sum;
  endfunction

  ////////////////////////////////////////////////////////////
  // sync shaping and data enable
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      de_q    <= 1'b0;
      hs_q    <= 1'b0;
      vs_q    <= 1'b0;
      hs_prev <= 1'b0;
      vs_prev <= 1'b0;
      hs_cnt  <= '0;
      out_de  <= 1'b0;
      out_hs  <= 1'b0;
      out_vs  <= 1'b0;
    end else begin
      de_q    <= ~(video_in.hblank | video_in.vblank);
      hs_q    <= video_in.hs;
      vs_q    <= video_in.vs;
      hs_prev <= hs_q;
      vs_prev <= vs_q;
      out_de  <= de_q;
      // vs goes out right away as a single pulse
      out_vs  <= vs_q & ~vs_prev;
      // hs is pushed back so it does not land on top of vs
      out_hs  <= (hs_cnt == CNT_W'(1));
      if (hs_q && !hs_prev) begin
        hs_cnt <= CNT_W'(HS_DELAY);
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // pixel path
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (!de_q) begin
      pix_nxt = (settings.sgb_en && settings.border_en) ? BORDER_SLOT_CODE : '0;
    end else if (settings.bw_en) begin
      pix_nxt = '{r: luma(pix_q), g: luma(pix_q), b: luma(pix_q)};
    end else begin
      pix_nxt = pix_q;
    end
  end

  always_ff @(posedge clk_sys) begin
    // blanked pixels are dropped at the input
    pix_q   <= (video_in.hblank | video_in.vblank) ? '0 : video_in.pixel;
    out_pix <= pix_nxt;
  end

  assign video_out = '{pixel: out_pix, de: out_de, hs: out_hs, vs: out_vs};

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_core_shell

output=$(./obj_dir/Vtb_core_shell 2>&1) || { echo "$output"; exit 1; }
echo "$output"

if grep -q "TESTBENCH PASSED" <<< "$output"; then
  exit 0
fi
exit 1

/* sim.f */
hdl/core_cfg_pkg.sv
hdl/av_pkg.sv
hdl/settings_regs.sv
hdl/core_reset_timer.sv
hdl/ff_control.sv
hdl/video_out_fmt.sv
hdl/core_shell_top.sv
tb/core_shell_checker.sv
tb/tb_core_shell.sv

/* tb/core_shell_checker.sv */
`timescale 1ns/1ps

module core_shell_checker
  import core_cfg_pkg::*;
  import av_pkg::*;
(
  input logic       clk_sys,
  input logic       arst_n,
  input apb_req_t   apb_req,
  input apb_rsp_t   apb_rsp,
  input video_out_t video_out,
  input logic       reset_req,
  input logic       core_reset
);

  logic        req_seen;
  int unsigned fail_count = 0;

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      req_seen <= 1'b0;
    end else if (reset_req) begin
      req_seen <= 1'b1;
    end
  end

  // no wait states
  a_pready : assert property (@(posedge clk_sys) disable iff (!arst_n)
    (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
    else begin
      $error("pready low in an access cycle");
      fail_count++;
    end

  a_vs_pulse : assert property (@(posedge clk_sys) disable iff (!arst_n)
    video_out.vs |=> !video_out.vs)
    else begin
      $error("vs out longer than one cycle");
      fail_count++;
    end

  a_hs_pulse : assert property (@(posedge clk_sys) disable iff (!arst_n)
    video_out.hs |=> !video_out.hs)
    else begin
      $error("hs out longer than one cycle");
      fail_count++;
    end

  a_no_early_reset : assert property (@(posedge clk_sys) disable iff (!arst_n)
    !req_seen |-> !core_reset)
    else begin
      $error("core reset without a request");
      fail_count++;
    end

endmodule

bind core_shell_top core_shell_checker i_checker (
  .clk_sys    (clk_sys),
  .arst_n     (arst_n),
  .apb_req    (apb_req),
  .apb_rsp    (apb_rsp),
  .video_out  (video_out),
  .reset_req  (reset_req),
  .core_reset (core_reset)
);

/* tb/core_shell_stimulus.txt */
# name op arg_a arg_b arg_c, all args hex
# wr: addr data exp_reset | rd: addr exp_data exp_err | press: cycles dl_busy 0
# audio: left right 0 | pix: flags{hs,vs,hblank,vblank} 0 0
run_wr wr 08 12345690 0
run_rd rd 08 12345690 0
boot_wr wr 04 00000001 1
boot_rd rd 04 00000001 0
rst_rd rd 00 00000000 0
rst_wr wr 00 deadbeef 1
bad_wr wr 0c ffffffff 0
bad_rd rd 0c 00000000 1
run_keep rd 08 12345690 0
vid_bw pix 0 0 0
vid_hs pix 8 0 0
vid_vs pix 4 0 0
vid_border pix 2 0 0
run_plain wr 08 0000000c 0
vid_plain pix 0 0 0
vid_blank0 pix 1 0 0
ff_hold press 28 0 0
ff_tap press 5 0 0
aud_snd audio 1234 fedc 0
run_mute wr 08 00000008 0
aud_mute audio 7fff 8001 0
ff_tap2 press 5 0 0
aud_off audio 0111 0222 0
ff_busy press 5 1 0
run_noff wr 08 00000000 0
ff_noen press 5 0 0

/* tb/tb_core_shell.sv */
`timescale 1ns/1ps

module tb_core_shell
  import core_cfg_pkg::*;
  import av_pkg::*;
;

  localparam int RESET_HOLD = 20;
  localparam int TAP_CYCLES = 16;
  localparam int HS_DELAY   = 7;

  logic        clk_sys;
  logic        arst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        ff_button;
  logic        dl_busy;
  audio_pair_t audio_in;
  audio_pair_t audio_out;
  video_in_t   video_in;
  video_out_t  video_out;
  logic        fast_forward;
  logic        core_reset;

  // test records
  string       rec_name[$];
  string       rec_op[$];
  logic [31:0] rec_a[$];
  logic [31:0] rec_b[$];
  logic [31:0] rec_c[$];

  // reference state
  logic [31:0] boot_model;
  logic [31:0] run_model;
  logic        ff_model;
  logic        hs_last;
  logic        vs_last;
  int          cycles;
  int          limit;

  core_shell_top #(
    .RESET_HOLD (RESET_HOLD),
    .TAP_CYCLES (TAP_CYCLES),
    .HS_DELAY   (HS_DELAY)
  ) i_dut (
    .clk_sys      (clk_sys),
    .arst_n       (arst_n),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .ff_button    (ff_button),
    .dl_busy      (dl_busy),
    .audio_in     (audio_in),
    .audio_out    (audio_out),
    .video_in     (video_in),
    .video_out    (video_out),
    .fast_forward (fast_forward),
    .core_reset   (core_reset)
  );

  initial begin
    clk_sys = 1'b0;
    forever #5 clk_sys = ~clk_sys;
  end

  always @(posedge clk_sys) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $fatal(1, "run did not finish in time");
    end else if (i_dut.i_checker.fail_count != 0) begin
      $display("a bound assertion on the DUT failed");
      $display("TESTBENCH FAILED");
      $fatal(1, "checker assertion failed");
    end
  end

  task automatic check_val(input string test, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("error: %s expected %h actual %h", test, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch in %s", test);
    end
  endtask

  task automatic step();
    @(posedge clk_sys);
    #1;
  endtask

  // luma as a weighted sum of truncated terms
  function automatic logic [7:0] luma_of(pixel_t p);
    int s;
    s = p.r / 4 + p.r / 32 + p.g / 2 + p.g / 16 + p.b / 16 + p.b / 32;
    return s[7:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // operations
  ////////////////////////////////////////////////////////////

  task automatic apb_write(input string test, input logic [31:0] addr, input logic [31:0] data,
                           input logic exp_rst);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr[7:0], pwdata: data};
    step();
    apb_req.penable = 1'b1;
    step();
    apb_req = '0;
    if (addr[7:0] == OFS_BOOT) boot_model = data;
    if (addr[7:0] == OFS_RUN) run_model = data;
    // core reset spans edges 2 to RESET_HOLD+1 after the access edge
    for (int i = 1; i <= RESET_HOLD + 4; i++) begin
      step();
      check_val(test, exp_rst && i >= 2 && i <= RESET_HOLD + 1, core_reset);
    end
  endtask

  task automatic apb_read(input string test, input logic [31:0] addr, input logic [31:0] exp_data,
                          input logic exp_err);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr[7:0], pwdata: '0};
    step();
    apb_req.penable = 1'b1;
    #1;
    check_val(test, exp_data, apb_rsp.prdata);
    check_val(test, exp_err, apb_rsp.pslverr);
    step();
    apb_req = '0;
  endtask

  task automatic button_press(input string test, input int len, input logic busy);
    logic qual;
    qual = run_model[RUN_FF_EN_BIT] && !busy;
    dl_busy   = busy;
    ff_button = 1'b1;
    for (int i = 0; i < len; i++) begin
      step();
      check_val(test, qual ? 1'b1 : ff_model, fast_forward);
    end
    ff_button = 1'b0;
    if (qual) ff_model = ff_model ? 1'b0 : (len < TAP_CYCLES);
    step();
    check_val(test, ff_model, fast_forward);
    dl_busy = 1'b0;
  endtask

  task automatic audio_sample(input string test, input logic [15:0] l, input logic [15:0] r);
    logic mute;
    mute = ff_model && !run_model[RUN_FF_SND_BIT];
    audio_in = '{left: l, right: r};
    #2;
    check_val(test, mute ? 32'h0 : {l, r}, audio_out);
    step();
  endtask

  task automatic pixel_flags(input string test, input logic [3:0] flags);
    pixel_t p;
    pixel_t exp_pix;
    logic   de;
    logic   hs_rise;
    logic   vs_rise;
    p = pixel_t'(24'($urandom));
    video_in = '{pixel: p, hs: flags[3], vs: flags[2], hblank: flags[1], vblank: flags[0]};
    de = !(flags[1] || flags[0]);
    hs_rise = flags[3] && !hs_last;
    vs_rise = flags[2] && !vs_last;
    hs_last = flags[3];
    vs_last = flags[2];
    if (!de) begin
      exp_pix = (boot_model[BOOT_SGB_BIT] && run_model[RUN_BORDER_BIT]) ? 24'h002000 : 24'h0;
    end else if (run_model[RUN_BW_BIT]) begin
      exp_pix = {3{luma_of(p)}};
    end else begin
      exp_pix = p;
    end
    for (int i = 1; i <= HS_DELAY + 2; i++) begin
      step();
      if (i == 2) begin
        check_val(test, exp_pix, video_out.pixel);
        check_val(test, de, video_out.de);
      end
      check_val(test, vs_rise && i == 2, video_out.vs);
      check_val(test, hs_rise && i == HS_DELAY + 2, video_out.hs);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          n;
    int          total;
    string       line;
    string       nm;
    string       op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    void'($urandom(78));
    arst_n = 1'b0;
    apb_req = '0;
    ff_button = 1'b0;
    dl_busy = 1'b0;
    audio_in = '0;
    video_in = '0;
    boot_model = '0;
    run_model = '0;
    ff_model = 1'b0;
    hs_last = 1'b0;
    vs_last = 1'b0;
    cycles = 0;
    limit = 0;
    total = 0;
    fd = $fopen("tb/core_shell_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file");
      $display("TESTBENCH FAILED");
      $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%s %s %h %h %h", nm, op, a, b, c);
      if (n != 5) continue;
      rec_name.push_back(nm);
      rec_op.push_back(op);
      rec_a.push_back(a);
      rec_b.push_back(b);
      rec_c.push_back(c);
      case (op)
        "wr":    total += RESET_HOLD + 6;
        "rd":    total += 2;
        "press": total += a + 2;
        "audio": total += 1;
        default: total += HS_DELAY + 2;
      endcase
    end
    $fclose(fd);
    if (rec_op.size() == 0) begin
      $display("no test records in the stimulus file");
      $display("TESTBENCH FAILED");
      $fatal(1, "empty stimulus");
    end
    limit = 2 * total + 200;
    repeat (4) @(posedge clk_sys);
    #1;
    arst_n = 1'b1;
    step();
    foreach (rec_op[i]) begin
      case (rec_op[i])
        "wr":    apb_write(rec_name[i], rec_a[i], rec_b[i], rec_c[i][0]);
        "rd":    apb_read(rec_name[i], rec_a[i], rec_b[i], rec_c[i][0]);
        "press": button_press(rec_name[i], rec_a[i], rec_b[i][0]);
        "audio": audio_sample(rec_name[i], rec_a[i][15:0], rec_b[i][15:0]);
        "pix":   pixel_flags(rec_name[i], rec_a[i][3:0]);
        default: begin
          $display("unknown operation %s in record %s", rec_op[i], rec_name[i]);
          $display("TESTBENCH FAILED");
          $fatal(1, "bad stimulus record");
        end
      endcase
    end
    if (i_dut.i_checker.fail_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1, "checker assertion failed");
    end
  end

endmodule
